// File: hw/rv32i_pkg.sv
package rv32i_pkg;

    // a data word or a raw instruction word
    typedef logic [31:0] word_t;

    // an architectural register index, register 0 always reads as zero
    typedef logic [4:0] reg_idx_t;

    // number of architectural registers
    localparam int NUM_REGS = 32;

    // instruction class, taken from the 7-bit major opcode
    // the encodings are the RV32I major opcodes themselves, so the decoder
    // can compare the opcode field against the enum values directly
    typedef enum logic [6:0] {
        // register-register arithmetic
        op_reg     = 7'b0110011,
        // register-immediate arithmetic
        op_imm     = 7'b0010011,
        // loads write rd and read rs1 for the address
        op_load    = 7'b0000011,
        // stores read rs1 and rs2 and write no register
        op_store   = 7'b0100011,
        // conditional branches compare rs1 with rs2
        op_branch  = 7'b1100011,
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        // any major opcode outside the base integer set
        op_illegal = 7'b0000000
    } opcode_t;

    // bit positions of the register fields inside an instruction word
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // width of the major opcode field, which sits at bit 0
    localparam int OPCODE_W = 7;

endpackage : rv32i_pkg

// File: hw/rob_pkg.sv
package rob_pkg;

    // number of reorder-buffer entries, a power of two from 2 to 16
    localparam int ROB_DEPTH = 8;

    // width of the head and tail pointers
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH);

    // producer tag, wide enough to name entry 16 of the largest buffer
    typedef logic [4:0] tag_t;

    // tag 0 marks a register whose committed value is current
    // entry i of the buffer is named by tag i+1
    localparam tag_t NO_TAG = 5'd0;

    // life cycle of one reorder-buffer entry
    typedef enum logic [1:0] {
        // entry holds nothing and can be allocated
        st_free,
        // entry allocated, result not yet written back
        st_busy,
        // result written back, waiting to reach the head
        st_done
    } entry_state_t;

endpackage : rob_pkg

// File: hw/instr_decoder.sv
module instr_decoder (
    input  rv32i_pkg::word_t    instr,
    input  logic                instr_valid,
    input  logic                full,
    output rv32i_pkg::opcode_t  op,
    output rv32i_pkg::reg_idx_t rs1,
    output rv32i_pkg::reg_idx_t rs2,
    output rv32i_pkg::reg_idx_t rd,
    output logic                load_tag,
    output logic                issue_valid
);

    // which register fields the current class really uses
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;

    always_comb begin
        // unknown opcodes read and write nothing
        op       = rv32i_pkg::op_illegal;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        uses_rd  = 1'b0;
        case (instr[rv32i_pkg::OPCODE_W-1:0])
            rv32i_pkg::op_reg: begin
                op       = rv32i_pkg::op_reg;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd  = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                op       = rv32i_pkg::op_imm;
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
            end
            rv32i_pkg::op_load: begin
                op       = rv32i_pkg::op_load;
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
            end
            // stores and branches have no destination, bits 11:7 hold immediate bits
            rv32i_pkg::op_store: begin
                op       = rv32i_pkg::op_store;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            rv32i_pkg::op_branch: begin
                op       = rv32i_pkg::op_branch;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            // upper-immediate forms and jal only write rd
            rv32i_pkg::op_lui: begin
                op      = rv32i_pkg::op_lui;
                uses_rd = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                op      = rv32i_pkg::op_auipc;
                uses_rd = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                op      = rv32i_pkg::op_jal;
                uses_rd = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                op       = rv32i_pkg::op_jalr;
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
            end
            default: begin
                op = rv32i_pkg::op_illegal;
            end
        endcase
    end

    // unused fields are reported as register 0 so they never pick up a tag
    assign rs1 = uses_rs1 ? instr[rv32i_pkg::RS1_LSB +: 5] : '0;
    assign rs2 = uses_rs2 ? instr[rv32i_pkg::RS2_LSB +: 5] : '0;
    assign rd  = uses_rd  ? instr[rv32i_pkg::RD_LSB  +: 5] : '0;

    // an instruction goes out whenever the buffer has room
    assign issue_valid = instr_valid && !full;

    // only a real destination is renamed and takes a buffer entry
    assign load_tag = issue_valid && (rd != '0);

endmodule : instr_decoder

// File: hw/regfile.sv
module regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    // rename request from the decoder
    input  logic                load_tag,
    input  rob_pkg::tag_t       tag_decoder,
    input  rv32i_pkg::reg_idx_t reg_id_decoder,
    input  rv32i_pkg::reg_idx_t rs1,
    input  rv32i_pkg::reg_idx_t rs2,

    // commit from the reorder buffer
    input  logic                load_reg,
    input  rv32i_pkg::reg_idx_t reg_id_rob,
    input  rv32i_pkg::word_t    reg_val,
    input  rob_pkg::tag_t       tag_rob,

    // operands and result tag toward the reservation stations
    output rv32i_pkg::word_t    vj_out,
    output rv32i_pkg::word_t    vk_out,
    output rob_pkg::tag_t       qj_out,
    output rob_pkg::tag_t       qk_out,
    output rob_pkg::tag_t       qi_out
);

    // committed architectural values
    rv32i_pkg::word_t values [rv32i_pkg::NUM_REGS];

    // producer tag of the next value of each register, NO_TAG when current
    rob_pkg::tag_t tags [rv32i_pkg::NUM_REGS];

    // register 0 reads as zero and is never waiting on a producer
    assign vj_out = (rs1 == '0) ? '0 : values[rs1];
    assign vk_out = (rs2 == '0) ? '0 : values[rs2];
    assign qj_out = (rs1 == '0) ? rob_pkg::NO_TAG : tags[rs1];
    assign qk_out = (rs2 == '0) ? rob_pkg::NO_TAG : tags[rs2];

    // the result tag is the one granted by this cycle's rename
    assign qi_out = load_tag ? tag_decoder : rob_pkg::NO_TAG;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv32i_pkg::NUM_REGS; i++) begin
                values[i] <= '0;
            end
        end else if (load_reg && reg_id_rob != '0) begin
            // a commit is final, so its value lands even during a flush
            values[reg_id_rob] <= reg_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // flush drops all in-flight producers, committed values stay
            for (int i = 0; i < rv32i_pkg::NUM_REGS; i++) begin
                tags[i] <= rob_pkg::NO_TAG;
            end
        end else begin
            // clear the tag only if this commit is still the newest producer
            // an older commit after a second rename leaves the newer tag alone
            if (load_reg && reg_id_rob != '0 && tags[reg_id_rob] == tag_rob) begin
                tags[reg_id_rob] <= rob_pkg::NO_TAG;
            end
            // a rename to the same register in this cycle overrides the clear
            if (load_tag) begin
                tags[reg_id_decoder] <= tag_decoder;
            end
        end
    end

endmodule : regfile

// File: hw/reorder_buffer.sv
module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    // allocation of a new entry for a renamed destination
    input  logic                alloc,
    input  rv32i_pkg::reg_idx_t alloc_reg,
    output rob_pkg::tag_t       alloc_tag,
    output logic                full,

    // results arriving from the execution units, in any order
    input  logic                wb_valid,
    input  rob_pkg::tag_t       wb_tag,
    input  rv32i_pkg::word_t    wb_value,

    // in-order commit toward the register file
    output logic                commit_valid,
    output rv32i_pkg::reg_idx_t commit_reg,
    output rv32i_pkg::word_t    commit_value,
    output rob_pkg::tag_t       commit_tag
);

    // per-entry state, destination register and result value
    rob_pkg::entry_state_t state [rob_pkg::ROB_DEPTH];
    rv32i_pkg::reg_idx_t   dest  [rob_pkg::ROB_DEPTH];
    rv32i_pkg::word_t      value [rob_pkg::ROB_DEPTH];

    // head is the oldest entry, tail the next one to allocate
    logic [rob_pkg::ROB_PTR_W-1:0] head;
    logic [rob_pkg::ROB_PTR_W-1:0] tail;

    // one extra bit so that a full buffer can be told from an empty one
    logic [rob_pkg::ROB_PTR_W:0] count;

    // writeback target, entry index is the tag minus one
    logic [rob_pkg::ROB_PTR_W-1:0] wb_idx;
    logic                          wb_hit;

    assign full = (count == rob_pkg::ROB_DEPTH);

    // entry i is named by tag i+1 so that tag 0 stays free for NO_TAG
    assign alloc_tag = rob_pkg::tag_t'(tail) + rob_pkg::tag_t'(1);

    assign wb_idx = rob_pkg::ROB_PTR_W'(wb_tag - rob_pkg::tag_t'(1));

    // results for tags outside the buffer or for idle entries are dropped
    assign wb_hit = wb_valid && wb_tag != rob_pkg::NO_TAG
                    && wb_tag <= rob_pkg::ROB_DEPTH
                    && state[wb_idx] == rob_pkg::st_busy;

    // the head commits as soon as its result is in
    // an empty buffer has a free head, so no extra count check is needed
    assign commit_valid = (state[head] == rob_pkg::st_done);
    assign commit_reg   = dest[head];
    assign commit_value = value[head];
    assign commit_tag   = rob_pkg::tag_t'(head) + rob_pkg::tag_t'(1);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // flush empties the buffer the same way reset does
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                state[i] <= rob_pkg::st_free;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // the decoder only allocates while the buffer has room
            if (alloc) begin
                state[tail] <= rob_pkg::st_busy;
                tail        <= tail + 1'b1;
            end
            if (wb_hit) begin
                state[wb_idx] <= rob_pkg::st_done;
            end
            // head and tail never collide here, the buffer is neither full nor empty
            if (commit_valid) begin
                state[head] <= rob_pkg::st_free;
                head        <= head + 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // destination and result payload only move with their strobes
    always_ff @(posedge clk) begin
        if (alloc) begin
            dest[tail] <= alloc_reg;
        end
        if (wb_hit) begin
            value[wb_idx] <= wb_value;
        end
    end

endmodule : reorder_buffer

// File: hw/rename_core.sv
module rename_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    // instruction stream
    input  logic                instr_valid,
    input  rv32i_pkg::word_t    instr,

    // results from the execution units
    input  logic                wb_valid,
    input  rob_pkg::tag_t       wb_tag,
    input  rv32i_pkg::word_t    wb_value,

    // issue toward the reservation stations
    output logic                issue_valid,
    output rv32i_pkg::opcode_t  issue_op,
    output rv32i_pkg::word_t    vj,
    output rv32i_pkg::word_t    vk,
    output rob_pkg::tag_t       qj,
    output rob_pkg::tag_t       qk,
    output rob_pkg::tag_t       qi,
    output logic                stall,

    // commits in program order
    output logic                commit_valid,
    output rv32i_pkg::reg_idx_t commit_reg,
    output rv32i_pkg::word_t    commit_value
);

    // decoded register fields and rename strobe
    rv32i_pkg::reg_idx_t rs1;
    rv32i_pkg::reg_idx_t rs2;
    rv32i_pkg::reg_idx_t rd;
    logic                load_tag;

    // next free tag, and the tag of the entry now committing
    rob_pkg::tag_t alloc_tag;
    rob_pkg::tag_t commit_tag;

    instr_decoder instr_decoder_i (
        .instr       (instr),
        .instr_valid (instr_valid),
        .full        (stall),
        .op          (issue_op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .load_tag    (load_tag),
        .issue_valid (issue_valid)
    );

    regfile regfile_i (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .load_tag       (load_tag),
        .tag_decoder    (alloc_tag),
        .reg_id_decoder (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .load_reg       (commit_valid),
        .reg_id_rob     (commit_reg),
        .reg_val        (commit_value),
        .tag_rob        (commit_tag),
        .vj_out         (vj),
        .vk_out         (vk),
        .qj_out         (qj),
        .qk_out         (qk),
        .qi_out         (qi)
    );

    // only renamed destinations take a buffer entry
    reorder_buffer reorder_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (load_tag),
        .alloc_reg    (rd),
        .alloc_tag    (alloc_tag),
        .full         (stall),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_value     (wb_value),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_value (commit_value),
        .commit_tag   (commit_tag)
    );

endmodule : rename_core

// File: tb/rename_core_properties.sv
module rename_core_properties (
    input logic                clk,
    input logic                rst,
    input logic                flush,
    input logic                stall,
    input logic                issue_valid,
    input rob_pkg::tag_t       qi,
    input logic                commit_valid,
    input rv32i_pkg::reg_idx_t commit_reg
);

    // a full buffer blocks every issue
    stall_blocks_issue: assert property (@(posedge clk) disable iff (rst)
        stall |-> !issue_valid)
        else $error("issue_valid high while stall is high");

    // only renamed destinations enter the buffer, and x0 is never renamed
    commit_not_x0: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_reg != '0)
        else $error("commit to register 0");

    // a granted tag always names an existing entry
    qi_in_range: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && qi != rob_pkg::NO_TAG) |-> qi <= rob_pkg::ROB_DEPTH)
        else $error("qi names an entry outside the reorder buffer");

    // flush empties the buffer, so nothing can commit right after it
    no_commit_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !commit_valid)
        else $error("commit in the cycle after a flush");

endmodule : rename_core_properties

bind rename_core rename_core_properties rename_core_properties_i (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .stall        (stall),
    .issue_valid  (issue_valid),
    .qi           (qi),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg)
);

// File: tb/rename_core_tb.sv
module rename_core_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DEPTH      = rob_pkg::ROB_DEPTH;

    typedef enum logic [1:0] {k_issue, k_wb, k_flush, k_idle} step_kind_t;

    // one table row, applied in one clock cycle
    typedef struct packed {
        step_kind_t         kind;
        logic [2:0]         grp;
        rv32i_pkg::opcode_t cls;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        // expected qi for an issue, the written tag for a writeback
        logic [4:0]         tag;
    } step_t;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                instr_valid;
    rv32i_pkg::word_t    instr;
    logic                wb_valid;
    rob_pkg::tag_t       wb_tag;
    rv32i_pkg::word_t    wb_value;
    logic                issue_valid;
    rv32i_pkg::opcode_t  issue_op;
    rv32i_pkg::word_t    vj;
    rv32i_pkg::word_t    vk;
    rob_pkg::tag_t       qj;
    rob_pkg::tag_t       qk;
    rob_pkg::tag_t       qi;
    logic                stall;
    logic                commit_valid;
    rv32i_pkg::reg_idx_t commit_reg;
    rv32i_pkg::word_t    commit_value;

    step_t steps [$];
    bit    table_ready = 1'b0;
    int    seed        = 32'hdfd12bfe;
    int    checks      = 0;
    int    errors      = 0;
    int    grp_errors  = 0;
    string grp_names [6];

    // reference model of committed state, producer tags and buffer entries
    // index 0 of m_val and m_tag is never written, so register 0 reads as zero
    logic [31:0]           m_val   [32] = '{default: '0};
    logic [4:0]            m_tag   [32] = '{default: '0};
    rob_pkg::entry_state_t r_state [16] = '{default: rob_pkg::st_free};
    logic [4:0]            r_dest  [16];
    logic [31:0]           r_value [16];
    int                    m_head  = 0;
    int                    m_tail  = 0;
    int                    m_count = 0;

    rename_core rename_core_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_value     (wb_value),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .vj           (vj),
        .vk           (vk),
        .qj           (qj),
        .qk           (qk),
        .qi           (qi),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_value (commit_value)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // register fields that each RV32I class really reads or writes
    function automatic bit reads_rs1(input rv32i_pkg::opcode_t c);
        return c != rv32i_pkg::op_lui && c != rv32i_pkg::op_auipc
               && c != rv32i_pkg::op_jal && c != rv32i_pkg::op_illegal;
    endfunction

    function automatic bit reads_rs2(input rv32i_pkg::opcode_t c);
        return c == rv32i_pkg::op_reg || c == rv32i_pkg::op_store || c == rv32i_pkg::op_branch;
    endfunction

    function automatic bit writes_rd(input rv32i_pkg::opcode_t c);
        return c != rv32i_pkg::op_store && c != rv32i_pkg::op_branch
               && c != rv32i_pkg::op_illegal;
    endfunction

    // R-type layout, for stores and branches the rd slot holds immediate bits
    function automatic rv32i_pkg::word_t make_instr(input step_t st);
        return {7'b0, st.rs2, st.rs1, 3'b0, st.rd, st.cls};
    endfunction

    task automatic add_step(input step_kind_t kind, input int grp, input int tag);
        step_t st;
        st      = '0;
        st.kind = kind;
        st.grp  = grp;
        st.tag  = tag;
        st.cls  = rv32i_pkg::op_illegal;
        steps.push_back(st);
    endtask

    task automatic add_issue(input int grp, input rv32i_pkg::opcode_t cls,
                             input int rd, input int rs1, input int rs2, input int exp_qi);
        step_t st;
        st      = '0;
        st.kind = k_issue;
        st.grp  = grp;
        st.cls  = cls;
        st.rd   = rd;
        st.rs1  = rs1;
        st.rs2  = rs2;
        st.tag  = exp_qi;
        steps.push_back(st);
    endtask

    task automatic add_idle(input int grp, input int n);
        for (int i = 0; i < n; i++) begin
            add_step(k_idle, grp, 0);
        end
    endtask

    task automatic build_table();
        grp_names = '{"rename", "register zero", "in-order commit", "stale commit",
                      "flush", "full buffer"};
        // three chained writers, each reader sees the previous tag and value 0
        add_issue(0, rv32i_pkg::op_imm, 1, 0, 0, 1);
        add_issue(0, rv32i_pkg::op_reg, 2, 1, 1, 2);
        add_issue(0, rv32i_pkg::op_reg, 3, 2, 0, 3);
        // rd 0, a store and a branch take no tag, x4 is read before its rename lands
        add_issue(1, rv32i_pkg::op_imm, 0, 1, 0, 0);
        add_issue(1, rv32i_pkg::op_store, 5, 0, 2, 0);
        add_issue(1, rv32i_pkg::op_branch, 4, 3, 0, 0);
        add_issue(1, rv32i_pkg::op_reg, 4, 5, 4, 4);
        add_issue(1, rv32i_pkg::op_imm, 6, 4, 0, 5);
        // results arrive out of order and must leave in allocation order
        add_step(k_wb, 2, 3);
        add_step(k_wb, 2, 2);
        add_idle(2, 1);
        add_step(k_wb, 2, 1);
        add_step(k_wb, 2, 5);
        add_step(k_wb, 2, 4);
        add_idle(2, 4);
        add_issue(2, rv32i_pkg::op_reg, 7, 1, 3, 6);
        // x8 renamed twice, the older commit must keep tag 8 in place
        add_issue(3, rv32i_pkg::op_imm, 8, 0, 0, 7);
        add_issue(3, rv32i_pkg::op_imm, 8, 8, 0, 8);
        add_step(k_wb, 3, 7);
        add_step(k_wb, 3, 6);
        add_idle(3, 2);
        add_issue(3, rv32i_pkg::op_imm, 9, 8, 0, 1);
        add_step(k_wb, 3, 8);
        add_idle(3, 2);
        add_issue(3, rv32i_pkg::op_imm, 10, 8, 0, 2);
        add_step(k_wb, 3, 1);
        add_step(k_wb, 3, 2);
        add_idle(3, 3);
        // flush with a done entry behind a busy head, so nothing commits
        add_issue(4, rv32i_pkg::op_imm, 11, 0, 0, 3);
        add_issue(4, rv32i_pkg::op_imm, 12, 11, 0, 4);
        add_step(k_wb, 4, 4);
        add_step(k_flush, 4, 0);
        add_idle(4, 1);
        add_issue(4, rv32i_pkg::op_reg, 13, 11, 8, 1);
        add_issue(4, rv32i_pkg::op_imm, 14, 10, 0, 2);
        add_step(k_wb, 4, 1);
        // x13 is renamed again in the very cycle that its first producer commits
        // the new tag has to survive the clear of that commit
        add_issue(4, rv32i_pkg::op_imm, 13, 13, 0, 3);
        add_issue(4, rv32i_pkg::op_imm, 0, 13, 0, 0);
        add_step(k_wb, 4, 2);
        add_step(k_wb, 4, 3);
        add_idle(4, 3);
        add_step(k_flush, 4, 0);
        add_idle(4, 1);
        // fill every entry from an empty buffer, then free one slot
        for (int i = 0; i < DEPTH; i++) begin
            add_issue(5, rv32i_pkg::op_imm, 16 + i, 0, 0, i + 1);
        end
        add_idle(5, 1);
        add_step(k_wb, 5, 1);
        add_idle(5, 2);
        add_issue(5, rv32i_pkg::op_imm, 15, 16, 0, 1);
        for (int i = 2; i <= DEPTH; i++) begin
            add_step(k_wb, 5, i);
        end
        add_step(k_wb, 5, 1);
        add_idle(5, DEPTH + 2);
    endtask

    task automatic drive_step(input step_t st);
        instr_valid = (st.kind == k_issue);
        instr       = (st.kind == k_issue) ? make_instr(st) : '0;
        wb_valid    = (st.kind == k_wb);
        wb_tag      = (st.kind == k_wb) ? st.tag : rob_pkg::NO_TAG;
        flush       = (st.kind == k_flush);
        if (st.kind == k_wb) begin
            wb_value = $random(seed);
        end else begin
            wb_value = '0;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %0s is %0h, expected %0h", $time, what, got, exp);
            errors++;
            grp_errors++;
        end
    endtask

    // compares the combinational outputs of this cycle with the model
    task automatic check_outputs(input step_t st);
        logic [4:0] src1;
        logic [4:0] src2;
        logic       exp_full;
        logic       commit_now;
        exp_full   = (m_count == DEPTH);
        commit_now = (r_state[m_head] == rob_pkg::st_done);
        check_value("stall", stall, exp_full);
        check_value("issue_valid", issue_valid, st.kind == k_issue && !exp_full);
        if (st.kind == k_issue) begin
            src1 = reads_rs1(st.cls) ? st.rs1 : 5'd0;
            src2 = reads_rs2(st.cls) ? st.rs2 : 5'd0;
            check_value("issue_op", issue_op, st.cls);
            check_value("qi", qi, st.tag);
            check_value("vj", vj, m_val[src1]);
            check_value("vk", vk, m_val[src2]);
            check_value("qj", qj, m_tag[src1]);
            check_value("qk", qk, m_tag[src2]);
        end
        checks++;
        assert (commit_valid === 1'b1 || !commit_now) else begin
            $display("ERROR at time %0t: the commit of tag %0d to register x%0d never arrived",
                     $time, m_head + 1, r_dest[m_head]);
            errors++;
            grp_errors++;
        end
        if (commit_now) begin
            check_value("commit_reg", commit_reg, r_dest[m_head]);
            check_value("commit_value", commit_value, r_value[m_head]);
        end else begin
            check_value("commit_valid", commit_valid, 1'b0);
        end
    endtask

    // applies the rising edge that ends the current step to the model
    task automatic advance_model(input step_t st);
        logic commit_now;
        logic alloc;
        logic wb_hit;
        int   wb_idx;
        int   d;
        commit_now = (r_state[m_head] == rob_pkg::st_done);
        alloc      = st.kind == k_issue && m_count != DEPTH && writes_rd(st.cls) && st.rd != 0;
        wb_idx     = int'(st.tag) - 1;
        wb_hit     = st.kind == k_wb && st.tag != 0 && st.tag <= DEPTH
                     && r_state[wb_idx] == rob_pkg::st_busy;
        d          = r_dest[m_head];
        // a commit is final and lands even in a flush cycle
        if (commit_now) begin
            m_val[d] = r_value[m_head];
        end
        if (st.kind == k_flush) begin
            m_tag   = '{default: '0};
            r_state = '{default: rob_pkg::st_free};
            m_head  = 0;
            m_tail  = 0;
            m_count = 0;
        end else begin
            // the clear comes first so that a rename in the same cycle wins
            if (commit_now && m_tag[d] == 5'(m_head + 1)) begin
                m_tag[d] = '0;
            end
            if (alloc) begin
                m_tag[st.rd]    = 5'(m_tail + 1);
                r_state[m_tail] = rob_pkg::st_busy;
                r_dest[m_tail]  = st.rd;
                m_tail          = (m_tail + 1) % DEPTH;
            end
            if (wb_hit) begin
                r_state[wb_idx] = rob_pkg::st_done;
                r_value[wb_idx] = wb_value;
            end
            if (commit_now) begin
                r_state[m_head] = rob_pkg::st_free;
                m_head          = (m_head + 1) % DEPTH;
            end
            m_count = m_count + int'(alloc) - int'(commit_now);
        end
    endtask

    initial begin
        step_t st;
        rst         = 1'b1;
        flush       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_valid    = 1'b0;
        wb_tag      = rob_pkg::NO_TAG;
        wb_value    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int s = 0; s < steps.size(); s++) begin
            @(negedge clk);
            st = steps[s];
            drive_step(st);
            // outputs have settled well before the next rising edge
            #(CLK_PERIOD / 10);
            check_outputs(st);
            advance_model(st);
            if (s == steps.size() - 1 || steps[s + 1].grp != st.grp) begin
                $display("test %0s: %0s (%0d errors)", grp_names[st.grp],
                         grp_errors == 0 ? "ok" : "failed", grp_errors);
                grp_errors = 0;
            end
        end
        @(negedge clk);
        drive_step('{kind: k_idle, cls: rv32i_pkg::op_illegal, default: '0});
        $display("%0d checks run, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // every step takes one cycle, so four cycles per step is a generous bound
    initial begin
        wait (table_ready);
        #((steps.size() * 4 + 10) * CLK_PERIOD);
        $display("timeout: the stimulus table did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : rename_core_tb

// File: flist.f
hw/rv32i_pkg.sv
hw/rob_pkg.sv
hw/instr_decoder.sv
hw/regfile.sv
hw/reorder_buffer.sv
hw/rename_core.sv
tb/rename_core_properties.sv
tb/rename_core_tb.sv
